// File: hdl/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  strb_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;

	localparam addr_t RESET_PC    = 32'h2000_0000;
	localparam word_t INST_EBREAK = 32'h0010_0073;

	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_SYSTEM = 7'b1110011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	typedef enum logic [2:0] {
		FETCH, WAIT_INST, DECODE, EXECUTE, MEM_REQ, MEM_WAIT, HALT
	} cpu_state_t;

	typedef struct packed {
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		funct3_t  funct3;
		alu_op_t  alu_op;
		logic     use_imm;
		logic     reg_wen;
		logic     is_load;
		logic     is_store;
		logic     is_branch;
		logic     is_jal;
		logic     is_jalr;
		logic     is_lui;
		logic     is_auipc;
		logic     is_ebreak;
	} ctrl_t;

	typedef struct packed {
		addr_t addr;
		word_t wdata;
		strb_t wstrb;
		logic  write;
	} mem_req_t;

endpackage

// File: hdl/cpu_idu.sv
`timescale 1ns/1ps
module cpu_idu (
	input  cpu_pkg::word_t inst,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::word_t imm
);
	import cpu_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	logic    funct7_5;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_u;
	word_t   imm_j;

	function automatic alu_op_t alu_sel(funct3_t f3, logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7_5 = inst[30];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl        = '0;
		ctrl.rd     = inst[11:7];
		ctrl.rs1    = inst[19:15];
		ctrl.rs2    = inst[24:20];
		ctrl.funct3 = funct3;
		ctrl.alu_op = ALU_ADD;
		imm         = '0;
		case (opcode)
			OP_LOAD: begin
				imm = imm_i;
				if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin // lb lh lw lbu lhu
					ctrl.is_load = 1'b1;
					ctrl.use_imm = 1'b1;
					ctrl.reg_wen = 1'b1;
				end
			end
			OP_STORE: begin
				imm = imm_s;
				if (!funct3[2] && funct3[1:0] != 2'b11) begin
					ctrl.is_store = 1'b1;
					ctrl.use_imm  = 1'b1;
				end
			end
			OP_IMM: begin
				imm          = imm_i;
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.alu_op  = alu_sel(funct3, funct7_5 && funct3 == 3'b101); // only srai
			end
			OP_REG: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_op  = alu_sel(funct3, funct7_5);
			end
			OP_LUI: begin
				imm          = imm_u;
				ctrl.is_lui  = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			OP_AUIPC: begin
				imm           = imm_u;
				ctrl.is_auipc = 1'b1;
				ctrl.reg_wen  = 1'b1;
			end
			OP_JAL: begin
				imm          = imm_j;
				ctrl.is_jal  = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			OP_JALR: begin
				imm          = imm_i;
				ctrl.is_jalr = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			OP_BRANCH: begin
				imm            = imm_b;
				ctrl.is_branch = (funct3[2:1] != 2'b01);
			end
			OP_SYSTEM: ctrl.is_ebreak = (inst == INST_EBREAK); // others run as nop
			default: ;
		endcase
		if (ctrl.rd == '0)
			ctrl.reg_wen = 1'b0;
	end

endmodule

// File: hdl/cpu_exu.sv
`timescale 1ns/1ps
module cpu_exu (
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::addr_t pc,
	input  cpu_pkg::word_t src1,
	input  cpu_pkg::word_t src2,
	input  cpu_pkg::word_t imm,
	output cpu_pkg::word_t result,
	output cpu_pkg::addr_t next_pc
);
	import cpu_pkg::*;

	word_t op2;
	word_t alu_out;
	addr_t pc_plus4;
	addr_t pc_plus_imm;
	logic  taken;

	assign op2         = ctrl.use_imm ? imm : src2;
	assign pc_plus4    = pc + 32'd4;
	assign pc_plus_imm = pc + imm;

	always_comb begin
		case (ctrl.alu_op)
			ALU_SUB:  alu_out = src1 - op2;
			ALU_SLL:  alu_out = src1 << op2[4:0];
			ALU_SLT:  alu_out = word_t'($signed(src1) < $signed(op2));
			ALU_SLTU: alu_out = word_t'(src1 < op2);
			ALU_XOR:  alu_out = src1 ^ op2;
			ALU_SRL:  alu_out = src1 >> op2[4:0];
			ALU_SRA:  alu_out = $signed(src1) >>> op2[4:0];
			ALU_OR:   alu_out = src1 | op2;
			ALU_AND:  alu_out = src1 & op2;
			default:  alu_out = src1 + op2;
		endcase
	end

	always_comb begin
		case (ctrl.funct3)
			3'b000:  taken = (src1 == src2);
			3'b001:  taken = (src1 != src2);
			3'b100:  taken = ($signed(src1) < $signed(src2));
			3'b101:  taken = ($signed(src1) >= $signed(src2));
			3'b110:  taken = (src1 < src2);
			3'b111:  taken = (src1 >= src2);
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.is_jal || ctrl.is_jalr)
			result = pc_plus4; // link
		else if (ctrl.is_lui)
			result = imm;
		else if (ctrl.is_auipc)
			result = pc_plus_imm;
		else
			result = alu_out;
	end

	always_comb begin
		if (ctrl.is_jalr)
			next_pc = {alu_out[31:1], 1'b0}; // rs1 + imm
		else if (ctrl.is_jal || (ctrl.is_branch && taken))
			next_pc = pc_plus_imm;
		else
			next_pc = pc_plus4;
	end

endmodule

// File: hdl/cpu_regfile.sv
`timescale 1ns/1ps
module cpu_regfile (
	input  logic              clock,
	input  logic              wen,
	input  cpu_pkg::reg_idx_t waddr,
	input  cpu_pkg::word_t    wdata,
	input  cpu_pkg::reg_idx_t raddr1,
	input  cpu_pkg::reg_idx_t raddr2,
	output cpu_pkg::word_t    rdata1,
	output cpu_pkg::word_t    rdata2
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clock) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1]; // x0 hardwired
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/cpu_lsu.sv
`timescale 1ns/1ps
module cpu_lsu (
	input  cpu_pkg::ctrl_t    ctrl,
	input  cpu_pkg::addr_t    addr,
	input  cpu_pkg::word_t    store_data,
	input  cpu_pkg::word_t    rsp_data,
	output cpu_pkg::mem_req_t req,
	output cpu_pkg::word_t    load_data
);
	import cpu_pkg::*;

	logic [4:0] shamt;
	strb_t      size_strb;
	word_t      lane_data;

	assign shamt = {addr[1:0], 3'b000}; // byte offset in bits

	always_comb begin
		case (ctrl.funct3[1:0])
			2'b00:   size_strb = 4'b0001;
			2'b01:   size_strb = 4'b0011;
			default: size_strb = 4'b1111;
		endcase
	end

	assign req.addr  = addr;
	assign req.wdata = store_data << shamt;
	assign req.wstrb = ctrl.is_store ? strb_t'(size_strb << addr[1:0]) : '0;
	assign req.write = ctrl.is_store;

	assign lane_data = rsp_data >> shamt; // addressed byte to bit 0

	always_comb begin
		case (ctrl.funct3)
			3'b000:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
			3'b001:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
			3'b100:  load_data = {24'b0, lane_data[7:0]};
			3'b101:  load_data = {16'b0, lane_data[15:0]};
			default: load_data = lane_data; // lw
		endcase
	end

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/1ps
module cpu_core (
	input  logic              clock,
	input  logic              reset,
	output cpu_pkg::mem_req_t mem_req,
	output logic              mem_req_valid,
	input  logic              mem_req_ready,
	input  logic              mem_rsp_valid,
	input  cpu_pkg::word_t    mem_rsp_data,
	output logic              halted
);
	import cpu_pkg::*;

	cpu_state_t state;
	addr_t      pc;
	word_t      ir;
	ctrl_t      ctrl;
	word_t      imm;
	word_t      src1;
	word_t      src2;
	word_t      result;
	addr_t      next_pc;
	mem_req_t   fetch_req;
	mem_req_t   lsu_req;
	word_t      load_data;
	word_t      wb_data;
	logic       wb_en;
	logic       req_fire;
	logic       is_mem;

	cpu_idu u_idu (
		.inst (ir),
		.ctrl (ctrl),
		.imm  (imm)
	);

	cpu_regfile u_regfile (
		.clock  (clock),
		.wen    (wb_en),
		.waddr  (ctrl.rd),
		.wdata  (wb_data),
		.raddr1 (ctrl.rs1),
		.raddr2 (ctrl.rs2),
		.rdata1 (src1),
		.rdata2 (src2)
	);

	cpu_exu u_exu (
		.ctrl    (ctrl),
		.pc      (pc),
		.src1    (src1),
		.src2    (src2),
		.imm     (imm),
		.result  (result),
		.next_pc (next_pc)
	);

	cpu_lsu u_lsu (
		.ctrl       (ctrl),
		.addr       (result),
		.store_data (src2),
		.rsp_data   (mem_rsp_data),
		.req        (lsu_req),
		.load_data  (load_data)
	);

	assign is_mem    = ctrl.is_load | ctrl.is_store;
	assign req_fire  = mem_req_valid & mem_req_ready;
	assign fetch_req = '{addr: pc, wdata: '0, wstrb: '0, write: 1'b0};
	assign mem_req   = (state == MEM_REQ) ? lsu_req : fetch_req;
	assign halted    = (state == HALT);

	assign wb_en   = ctrl.reg_wen & (((state == EXECUTE) & ~ctrl.is_load) |
		((state == MEM_WAIT) & mem_rsp_valid));
	assign wb_data = ctrl.is_load ? load_data : result; // result carries link too

	always_ff @(posedge clock) begin
		if (state == WAIT_INST && mem_rsp_valid)
			ir <= mem_rsp_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= FETCH;
			pc            <= RESET_PC;
			mem_req_valid <= 1'b0;
		end else begin
			case (state)
				FETCH: begin
					if (req_fire) begin
						mem_req_valid <= 1'b0;
						state         <= WAIT_INST;
					end else begin
						mem_req_valid <= 1'b1; // first fetch after reset
					end
				end
				WAIT_INST: if (mem_rsp_valid) state <= DECODE;
				DECODE: state <= EXECUTE;
				EXECUTE: begin
					if (ctrl.is_ebreak) begin
						state <= HALT;
					end else if (is_mem) begin
						state         <= MEM_REQ;
						mem_req_valid <= 1'b1;
					end else begin
						pc            <= next_pc;
						state         <= FETCH;
						mem_req_valid <= 1'b1;
					end
				end
				MEM_REQ: begin
					if (req_fire) begin
						mem_req_valid <= 1'b0;
						state         <= MEM_WAIT;
					end
				end
				MEM_WAIT: begin
					if (mem_rsp_valid) begin // store ack or load data
						pc            <= next_pc;
						state         <= FETCH;
						mem_req_valid <= 1'b1;
					end
				end
				HALT: mem_req_valid <= 1'b0;
				default: state <= FETCH;
			endcase
		end
	end

endmodule

// File: tests/cpu_clk_gen.sv
`timescale 1ns/1ps
module cpu_clk_gen (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	initial begin
		reset <= 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: tests/cpu_chk.sv
`timescale 1ns/1ps
module cpu_chk (
	input logic                clock,
	input logic                reset,
	input cpu_pkg::mem_req_t   mem_req,
	input logic                mem_req_valid,
	input logic                mem_req_ready,
	input logic                halted,
	input cpu_pkg::cpu_state_t state
);
	import cpu_pkg::*;

	int unsigned fail_count = 0;
	logic        reset_seen = 1'b0;

	always @(posedge clock)
		reset_seen <= reset; // skips the first edge, valid is still unknown there

	req_stable: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
		else begin
			fail_count++;
			$error("request payload changed while waiting for ready");
		end

	idle_when_stopped: assert property (@(posedge clock)
		(reset && reset_seen) || halted |-> !mem_req_valid)
		else begin
			fail_count++;
			$error("request valid during reset or after halt");
		end

	strb_needs_write: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid && mem_req.wstrb != '0 |-> mem_req.write)
		else begin
			fail_count++;
			$error("byte enables set on a read request");
		end

	fetch_aligned: assert property (@(posedge clock) disable iff (reset)
		mem_req_valid && state == FETCH |-> mem_req.addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("fetch address not word aligned");
		end

endmodule

bind cpu_core cpu_chk u_chk (
	.clock         (clock),
	.reset         (reset),
	.mem_req       (mem_req),
	.mem_req_valid (mem_req_valid),
	.mem_req_ready (mem_req_ready),
	.halted        (halted),
	.state         (state)
);

// File: tests/cpu_tb.sv
`timescale 1ns/1ps
module cpu_tb;
	import cpu_pkg::*;

	typedef struct packed {
		addr_t addr;
		word_t data;
		strb_t strb;
	} store_rec_t;

	logic        clock;
	logic        reset;
	mem_req_t    mem_req;
	logic        mem_req_valid;
	logic        mem_req_ready = 1'b0;
	logic        mem_rsp_valid = 1'b0;
	word_t       mem_rsp_data  = '0;
	logic        halted;

	word_t       mem [1024]; // 4 KB at RESET_PC
	bit          in_image [1024];
	store_rec_t  stores [$];
	int unsigned prog_words = 0;
	int unsigned ready_gap;
	int unsigned rsp_gap;
	bit          pending = 1'b0;
	bit          expect_data = 1'b0; // next request is the load/store of the last fetch
	bit          first_fetch = 1'b1;
	bit          seq_fetch   = 1'b0; // last fetch falls through to PC plus 4
	addr_t       next_fetch  = '0;
	word_t       rsp_word;

	cpu_clk_gen u_clk_gen (
		.clock (clock),
		.reset (reset)
	);

	cpu_core u_dut (
		.clock         (clock),
		.reset         (reset),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.halted        (halted)
	);

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_addr(string name, addr_t exp, addr_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_strb(string name, strb_t exp, strb_t act);
		if (act !== exp)
			abort_run($sformatf("Error: %s expected %h got %h", name, exp, act));
	endtask

	function automatic word_t lane_mask(strb_t strb);
		word_t mask;
		for (int i = 0; i < 4; i++)
			mask[8*i +: 8] = {8{strb[i]}};
		return mask;
	endfunction

	function automatic bit in_memory(addr_t addr);
		return (addr - RESET_PC) < 32'd4096; // wraps below the base too
	endfunction

	task automatic load_testdata();
		int    fd;
		int    code;
		string tag;
		string rest;
		addr_t addr;
		word_t data;
		strb_t strb;
		foreach (mem[i])
			mem[i] = '0; // unwritten memory reads zero
		fd = $fopen("tests/cpu_testdata.hex", "r");
		if (fd == 0)
			abort_run("cannot open tests/cpu_testdata.hex");
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "P") begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2 || !in_memory(addr))
					abort_run("malformed program record in the test data");
				mem[(addr - RESET_PC) >> 2]      = data;
				in_image[(addr - RESET_PC) >> 2] = 1'b1;
				prog_words++;
			end else if (tag == "S") begin
				code = $fscanf(fd, "%h %h %h", addr, data, strb);
				if (code != 3)
					abort_run("malformed store record in the test data");
				stores.push_back('{addr: addr, data: data, strb: strb});
			end else begin
				code = $fgets(rest, fd); // comment to end of line
			end
		end
		$fclose(fd);
	endtask

	task automatic serve_request(mem_req_t req);
		int unsigned idx;
		store_rec_t  exp;
		word_t       mask;
		if (!in_memory(req.addr))
			abort_run($sformatf("request to %h lies outside the memory", req.addr));
		idx      = (req.addr - RESET_PC) >> 2;
		rsp_word = mem[idx];
		if (!expect_data) begin
			if (first_fetch)
				check_addr("mem_req.addr", RESET_PC, req.addr);
			else if (seq_fetch)
				check_addr("mem_req.addr", next_fetch, req.addr);
			first_fetch = 1'b0;
			if (!in_image[idx])
				abort_run($sformatf("fetch from %h, outside the program", req.addr));
			if (req.write !== 1'b0)
				abort_run($sformatf("Error: mem_req.write expected 0 got %h", req.write));
			check_strb("mem_req.wstrb", '0, req.wstrb);
			next_fetch  = req.addr + 32'd4;
			seq_fetch   = (rsp_word[6:0] != OP_JAL) && (rsp_word[6:0] != OP_JALR) &&
				(rsp_word[6:0] != OP_BRANCH);
			expect_data = (rsp_word[6:0] == OP_LOAD) || (rsp_word[6:0] == OP_STORE);
		end else if (req.write) begin
			expect_data = 1'b0;
			if (stores.size() == 0)
				abort_run($sformatf("extra store to %h after all expected stores", req.addr));
			exp  = stores.pop_front();
			mask = lane_mask(req.wstrb);
			check_addr("mem_req.addr", exp.addr, req.addr);
			check_strb("mem_req.wstrb", exp.strb, req.wstrb);
			check_word("mem_req.wdata", exp.data & mask, req.wdata & mask);
			for (int b = 0; b < 4; b++)
				if (req.wstrb[b])
					mem[idx][8*b +: 8] = req.wdata[8*b +: 8];
		end else begin
			expect_data = 1'b0;
			check_strb("mem_req.wstrb", '0, req.wstrb);
		end
	endtask

	initial begin : memory_model
		void'($urandom(28902));
		load_testdata();
		forever begin
			@(posedge clock);
			if (reset) begin
				mem_req_ready <= 1'b0;
				mem_rsp_valid <= 1'b0;
				pending   = 1'b0;
				ready_gap = $urandom % 4;
			end else begin
				mem_rsp_valid <= 1'b0;
				if (pending && rsp_gap == 0) begin
					mem_rsp_valid <= 1'b1;
					mem_rsp_data  <= rsp_word;
					pending = 1'b0;
				end else if (pending) begin
					rsp_gap--;
				end
				if (mem_req_valid && mem_req_ready) begin
					mem_req_ready <= 1'b0;
					serve_request(mem_req);
					pending   = 1'b1;
					rsp_gap   = $urandom % 4;
					ready_gap = $urandom % 4;
				end else if (mem_req_valid && ready_gap == 0) begin
					mem_req_ready <= 1'b1;
				end else if (mem_req_valid) begin
					ready_gap--;
				end
			end
		end
	end

	always @(posedge clock) begin
		if (u_dut.u_chk.fail_count != 0)
			abort_run("a bus protocol assertion failed");
	end

	initial begin : watchdog
		wait (prog_words != 0);
		repeat (16 + 240 * prog_words) @(posedge clock);
		abort_run("watchdog expired, the core never halted");
	end

	initial begin : end_of_run
		do
			@(posedge clock);
		while (halted !== 1'b1);
		repeat (4) @(posedge clock);
		if (stores.size() != 0)
			abort_run($sformatf("core halted with %0d expected stores missing", stores.size()));
		else if (u_dut.u_chk.fail_count != 0)
			abort_run("a bus protocol assertion failed");
		else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: tests/cpu_testdata.hex
# P <address> <word>                  program image and data
# S <address> <lane data> <strobe>    expected stores in program order
P 20000000 200000b7 # lui x1, 0x20000
P 20000004 ffb00113 # addi x2, x0, -5
P 20000008 00c00193
P 2000000c 00310233 # add x4, x2, x3
P 20000010 4040a023
P 20000014 403102b3 # sub x5, x2, x3
P 20000018 4022d313 # srai x6, x5, 2
P 2000001c 003343b3
P 20000020 4070a223
P 20000024 0021b433 # sltu x8, x3, x2
P 20000028 00541493
P 2000002c 4090a423
P 20000030 00001517 # auipc x10, 1
P 20000034 40a0a623
P 20000038 00310463 # beq not taken
P 2000003c 00314463 # blt taken
P 20000040 4000a823 # skipped
P 20000044 008005ef # jal x11, +8
P 20000048 4000a823 # skipped
P 2000004c 40b0a823
P 20000050 05908667 # jalr x12, 0x59(x1)
P 20000054 4000aa23 # skipped
P 20000058 40c0aa23
P 2000005c 60008683 # lb x13
P 20000060 6020c703 # lbu x14
P 20000064 60209783 # lh x15
P 20000068 6000d803 # lhu x16
P 2000006c 42d080a3 # sb x13, 0x421(x1)
P 20000070 42f09123 # sh x15, 0x422(x1)
P 20000074 40e0ac23
P 20000078 41009e23 # sh x16, 0x41c(x1)
P 2000007c 4200a883 # lw x17, 0x420(x1)
P 20000080 4310a223
P 20000084 00100073 # ebreak
P 20000600 80f17f85 # load data
S 20000400 00000007 f
S 20000404 fffffff7 f
S 20000408 00000020 f
S 2000040c 20001030 f
S 20000410 20000048 f
S 20000414 20000054 f
S 20000421 00008500 2
S 20000422 80f10000 c
S 20000418 000000f1 f
S 2000041c 00007f85 3
S 20000424 80f18500 f

// File: project.f
hdl/cpu_pkg.sv
hdl/cpu_idu.sv
hdl/cpu_exu.sv
hdl/cpu_regfile.sv
hdl/cpu_lsu.sv
hdl/cpu_core.sv
tests/cpu_clk_gen.sv
tests/cpu_chk.sv
tests/cpu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cpu_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
